/* src/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int DIV_STEPS = 32;
    localparam int DIV_CW    = $clog2(DIV_STEPS);   // divider step counter width

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU,
        AND, OR, NOR, XOR,
        SLL, SRL, SRA, LUI,
        DIV, DIVU, MOD, MODU
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } st_size_e;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        alu_op_e           alu_op;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
        logic [XLEN-1:0]   rkd_value;      // store data
        logic              res_from_mem;   // load
        logic              mem_we;         // store
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        st_size_e          size;
        logic              ld_unsigned;
    } id_to_ex_t;

    typedef struct packed {
        logic              res_from_mem;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic [XLEN-1:0]   alu_result;
    } ex_fwd_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic              res_from_mem;
        logic              rf_we;
        logic [REG_AW-1:0] rf_waddr;
        logic [XLEN-1:0]   alu_result;
        logic [1:0]        addr_low;       // for load lane extraction
        st_size_e          size;
        logic              ld_unsigned;
    } ex_to_mem_t;

    typedef struct packed {
        logic            en;
        logic [3:0]      we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

endpackage

/* src/div_count.sv */
`timescale 1ns/10ps

module div_count (
    input  logic clk,
    input  logic resetn,
    input  logic load,
    input  logic dec,
    output logic last
);
    import ex_pkg::*;

    logic [DIV_CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= DIV_CW'(DIV_STEPS - 1);   // one step per quotient bit
        end else if (dec) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign last = (cnt == '0);

endmodule

/* src/div_ctrl.sv */
`timescale 1ns/10ps

module div_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic start,
    input  logic is_div,
    input  logic flush,
    input  logic item_release,
    input  logic last,
    output logic load,
    output logic step,
    output logic init,
    output logic done
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (start && is_div) state_nxt = RUN;
            RUN:  if (last) state_nxt = DONE;         // final step this cycle
            DONE: if (item_release) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
        if (flush) begin
            state_nxt = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign init = (state == IDLE) && start && is_div;
    assign load = init;                // counter restarts with the operands
    assign step = (state == RUN);
    assign done = (state == DONE);     // held while the item waits downstream

endmodule

/* src/div_core.sv */
`timescale 1ns/10ps

module div_core (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     init,
    input  logic                     step,
    input  logic [ex_pkg::XLEN-1:0]  dividend,
    input  logic [ex_pkg::XLEN-1:0]  divisor,
    input  logic                     is_signed,
    output logic [ex_pkg::XLEN-1:0]  quotient,
    output logic [ex_pkg::XLEN-1:0]  remainder
);
    import ex_pkg::*;

    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] q;          // dividend shifts out, quotient shifts in
    logic [XLEN-1:0] r;          // partial remainder
    logic [XLEN-1:0] b;          // divisor magnitude
    logic            q_neg;
    logic            r_neg;
    logic [XLEN:0]   shifted;
    logic [XLEN+1:0] diff;

    assign a_neg = is_signed & dividend[XLEN-1];
    assign b_neg = is_signed & divisor[XLEN-1];

    assign shifted = {r, q[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, b};   // msb set means borrow

    always_ff @(posedge clk) begin
        if (init) begin
            q <= a_neg ? -dividend : dividend;
            r <= '0;
            b <= b_neg ? -divisor : divisor;
        end else if (step) begin
            q <= {q[XLEN-2:0], ~diff[XLEN+1]};
            r <= diff[XLEN+1] ? shifted[XLEN-1:0] : diff[XLEN-1:0];   // restore on borrow
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_neg <= 1'b0;
            r_neg <= 1'b0;
        end else if (init) begin
            q_neg <= a_neg ^ b_neg;
            r_neg <= a_neg;      // remainder follows the dividend
        end
    end

    assign quotient  = q_neg ? -q : q;
    assign remainder = r_neg ? -r : r;

endmodule

/* src/ex_alu.sv */
`timescale 1ns/10ps

module ex_alu (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    flush,
    input  logic                    start,
    input  logic                    item_release,
    input  ex_pkg::alu_op_e         alu_op,
    input  logic [ex_pkg::XLEN-1:0] src1,
    input  logic [ex_pkg::XLEN-1:0] src2,
    output logic [ex_pkg::XLEN-1:0] result,
    output logic                    complete
);
    import ex_pkg::*;

    logic            is_div;
    logic            is_signed;
    logic            pick_quot;
    logic [XLEN-1:0] simple_res;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            load;
    logic            step;
    logic            init;
    logic            done;
    logic            last;

    assign is_div    = (alu_op == DIV) || (alu_op == DIVU) || (alu_op == MOD) || (alu_op == MODU);
    assign is_signed = (alu_op == DIV) || (alu_op == MOD);
    assign pick_quot = (alu_op == DIV) || (alu_op == DIVU);

    always_comb begin
        case (alu_op)
            ADD:     simple_res = src1 + src2;
            SUB:     simple_res = src1 - src2;
            SLT:     simple_res = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            SLTU:    simple_res = {{(XLEN-1){1'b0}}, src1 < src2};
            AND:     simple_res = src1 & src2;
            OR:      simple_res = src1 | src2;
            NOR:     simple_res = ~(src1 | src2);
            XOR:     simple_res = src1 ^ src2;
            SLL:     simple_res = src1 << src2[4:0];
            SRL:     simple_res = src1 >> src2[4:0];
            SRA:     simple_res = $signed(src1) >>> src2[4:0];
            LUI:     simple_res = src2;            // decode already placed the immediate
            default: simple_res = '0;              // divides come from div_core
        endcase
    end

    div_ctrl u_div_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .is_div       (is_div),
        .flush        (flush),
        .item_release (item_release),
        .last         (last),
        .load         (load),
        .step         (step),
        .init         (init),
        .done         (done)
    );

    div_count u_div_count (
        .clk    (clk),
        .resetn (resetn),
        .load   (load),
        .dec    (step),
        .last   (last)
    );

    div_core u_div_core (
        .clk       (clk),
        .resetn    (resetn),
        .init      (init),
        .step      (step),
        .dividend  (src1),
        .divisor   (src2),
        .is_signed (is_signed),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign result   = !is_div ? simple_res : (pick_quot ? quotient : remainder);
    assign complete = is_div ? done : start;   // single-cycle ops finish at once

endmodule

/* src/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    flush,
    input  logic                    later_excep,
    // decode side
    input  logic                    id_to_ex_valid,
    input  ex_pkg::id_to_ex_t       id_to_ex,
    output logic                    ex_allowin,
    // memory side
    input  logic                    mem_allowin,
    output logic                    ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t      ex_to_mem,
    output ex_pkg::ex_fwd_t         ex_fwd,
    output ex_pkg::mem_req_t        mem_req,
    // alu handshake
    output ex_pkg::alu_op_e         alu_op,
    output logic [ex_pkg::XLEN-1:0] alu_src1,
    output logic [ex_pkg::XLEN-1:0] alu_src2,
    output logic                    alu_start,
    output logic                    alu_release,
    input  logic [ex_pkg::XLEN-1:0] alu_result,
    input  logic                    alu_complete
);
    import ex_pkg::*;

    logic            ex_valid;
    id_to_ex_t       item;
    logic            ready_go;
    logic [1:0]      addr_low;
    logic [3:0]      lane_we;
    logic [XLEN-1:0] st_data;

    assign ready_go        = alu_complete;   // wait on the alu
    assign ex_allowin      = !ex_valid || (ready_go && mem_allowin);
    assign ex_to_mem_valid = ex_valid && ready_go;
    assign alu_release     = ex_to_mem_valid && mem_allowin;   // item leaves this edge

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;            // incoming item dropped too
        end else if (ex_allowin) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            item <= id_to_ex;
        end
    end

    assign alu_op    = item.alu_op;
    assign alu_src1  = item.src1;
    assign alu_src2  = item.src2;
    assign alu_start = ex_valid;

    assign addr_low = alu_result[1:0];

    always_comb begin
        case (item.size)
            BYTE: begin
                lane_we = 4'b0001 << addr_low;
                st_data = {4{item.rkd_value[7:0]}};
            end
            HALF: begin
                lane_we = addr_low[1] ? 4'b1100 : 4'b0011;
                st_data = {2{item.rkd_value[15:0]}};
            end
            default: begin
                lane_we = 4'b1111;       // word
                st_data = item.rkd_value;
            end
        endcase
    end

    assign mem_req.en    = ex_valid && (item.res_from_mem || item.mem_we) && !later_excep;
    assign mem_req.we    = {4{ex_valid && item.mem_we}} & lane_we;
    assign mem_req.addr  = alu_result;
    assign mem_req.wdata = st_data;

    // back to decode for bypass and load-use stall
    assign ex_fwd.res_from_mem = item.res_from_mem && ex_valid;
    assign ex_fwd.rf_we        = item.rf_we && ex_valid;
    assign ex_fwd.rf_waddr     = item.rf_waddr;
    assign ex_fwd.alu_result   = alu_result;

    assign ex_to_mem.pc           = item.pc;
    assign ex_to_mem.res_from_mem = item.res_from_mem && ex_valid;
    assign ex_to_mem.rf_we        = item.rf_we && ex_valid;
    assign ex_to_mem.rf_waddr     = item.rf_waddr;
    assign ex_to_mem.alu_result   = alu_result;
    assign ex_to_mem.addr_low     = addr_low;
    assign ex_to_mem.size         = item.size;
    assign ex_to_mem.ld_unsigned  = item.ld_unsigned;

endmodule

/* src/ex_top.sv */
`timescale 1ns/10ps

module ex_top (
    input  logic               clk,
    input  logic               resetn,
    input  logic               flush,
    input  logic               later_excep,
    input  logic               id_to_ex_valid,
    input  ex_pkg::id_to_ex_t  id_to_ex,
    output logic               ex_allowin,
    input  logic               mem_allowin,
    output logic               ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t ex_to_mem,
    output ex_pkg::ex_fwd_t    ex_fwd,
    output ex_pkg::mem_req_t   mem_req
);
    import ex_pkg::*;

    alu_op_e         alu_op;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic            alu_start;
    logic            alu_release;
    logic [XLEN-1:0] alu_result;
    logic            alu_complete;

    ex_stage u_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .flush           (flush),
        .later_excep     (later_excep),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex        (id_to_ex),
        .ex_allowin      (ex_allowin),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem       (ex_to_mem),
        .ex_fwd          (ex_fwd),
        .mem_req         (mem_req),
        .alu_op          (alu_op),
        .alu_src1        (alu_src1),
        .alu_src2        (alu_src2),
        .alu_start       (alu_start),
        .alu_release     (alu_release),
        .alu_result      (alu_result),
        .alu_complete    (alu_complete)
    );

    ex_alu u_ex_alu (
        .clk          (clk),
        .resetn       (resetn),
        .flush        (flush),
        .start        (alu_start),
        .item_release (alu_release),
        .alu_op       (alu_op),
        .src1         (alu_src1),
        .src2         (alu_src2),
        .result       (alu_result),
        .complete     (alu_complete)
    );

endmodule

/* tb/tb_ex_top.sv */
`timescale 1ns/10ps

module tb_ex_top;
    import ex_pkg::*;

    localparam int NV        = 24;              // vectors in the file
    localparam int NF        = 10;              // fields per vector
    localparam int FLUSH_IDX = NV - 2;          // divide that gets flushed
    localparam int LX_FIRST  = 21;              // later_excep while 20 and 21 sit in the stage
    localparam int LX_LAST   = 22;
    localparam int LIMIT     = NV * 40 + 100;

    logic       clk;
    logic       resetn;
    logic       flush;
    logic       later_excep;
    logic       id_to_ex_valid;
    id_to_ex_t  id_to_ex;
    logic       ex_allowin;
    logic       mem_allowin;
    logic       ex_to_mem_valid;
    ex_to_mem_t ex_to_mem;
    ex_fwd_t    ex_fwd;
    mem_req_t   mem_req;

    logic [31:0] vec [0:NV*NF-1];
    int          pending[$];                    // accepted, not yet left
    int          cur_vec;
    int          cycles;
    int          checks;
    int          errors;
    int          departed;
    logic [31:0] lcg_state;
    logic        hold_prev;
    logic        lx_prev;
    ex_to_mem_t  to_mem_prev;
    mem_req_t    req_prev;

    ex_top UUT (
        .clk             (clk),
        .resetn          (resetn),
        .flush           (flush),
        .later_excep     (later_excep),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_to_ex        (id_to_ex),
        .ex_allowin      (ex_allowin),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem       (ex_to_mem),
        .ex_fwd          (ex_fwd),
        .mem_req         (mem_req)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic id_to_ex_t make_item(input int i);
        id_to_ex_t t;
        int        b;
        b              = i * NF;
        t.pc           = 32'h1c00_0000 + 32'(i * 4);
        t.alu_op       = alu_op_e'(vec[b][3:0]);
        t.src1         = vec[b+1];
        t.src2         = vec[b+2];
        t.rkd_value    = vec[b+3];
        t.size         = st_size_e'(vec[b+4][1:0]);
        t.mem_we       = vec[b+5][0];
        t.res_from_mem = vec[b+6][0];
        t.rf_we        = vec[b+7][0];
        t.rf_waddr     = vec[b+8][4:0];
        t.ld_unsigned  = i[0];                  // odd vectors load unsigned
        return t;
    endfunction

    // request the stage should raise for item v with address res
    function automatic mem_req_t expect_req(input id_to_ex_t v, input logic [XLEN-1:0] res,
                                            input logic lx);
        mem_req_t m;
        m.en   = (v.res_from_mem || v.mem_we) && !lx;
        m.addr = res;
        m.we   = 4'b0000;
        case (v.size)
            BYTE: begin
                m.wdata = {4{v.rkd_value[7:0]}};
                if (v.mem_we) m.we[res[1:0]] = 1'b1;     // one lane per byte
            end
            HALF: begin
                m.wdata = {2{v.rkd_value[15:0]}};
                if (v.mem_we) m.we = res[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                m.wdata = v.rkd_value;
                if (v.mem_we) m.we = 4'b1111;
            end
        endcase
        return m;
    endfunction

    task automatic check_word(input logic [XLEN-1:0] act, input logic [XLEN-1:0] exp,
                              input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_mem_req(input mem_req_t act, input mem_req_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, act, exp);
        end
    endtask

    // full also compares rf_waddr and the result
    task automatic check_fwd(input ex_fwd_t act, input ex_fwd_t exp, input logic full,
                             input string what);
        logic bad;
        checks++;
        bad = (act.res_from_mem !== exp.res_from_mem) || (act.rf_we !== exp.rf_we);
        if (full && act !== exp) bad = 1'b1;
        if (bad) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, act, exp);
        end
    endtask

    task automatic check_to_mem(input ex_to_mem_t act, input ex_to_mem_t exp, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, act, exp);
        end
    endtask

    // present vector i until the stage takes it
    task automatic send(input int i);
        @(posedge clk);
        cur_vec = i;
        id_to_ex_valid <= 1'b1;
        id_to_ex       <= make_item(i);
        later_excep    <= (i >= LX_FIRST) && (i <= LX_LAST);
        @(negedge clk);
        while (!ex_allowin) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        lcg_state = 32'h2170_02cf;
        mem_allowin <= 1'b0;
        forever begin
            @(posedge clk);
            lcg_state = lcg_next(lcg_state);
            mem_allowin <= resetn && ((lcg_state[31:16] % 16'd3) != 16'd0);   // low ~1/3
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: pipeline stalled at vector %0d after %0d cycles", cur_vec, cycles);
            $display("checks %0d, errors %0d, results %0d", checks, errors, departed);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // outputs are stable here, inputs change only on the rising edge
    always @(negedge clk) begin
        id_to_ex_t       v;
        logic [XLEN-1:0] res;
        ex_fwd_t         fwd_exp;
        ex_to_mem_t      to_mem_exp;
        if (cycles > 0) begin
            if (!resetn || pending.size() == 0) begin
                fwd_exp = '0;
                check_word(32'(ex_to_mem_valid), 32'd0, "ex_to_mem_valid with stage empty");
                check_word(32'(mem_req.en), 32'd0, "mem_req.en with stage empty");
                check_word(32'(ex_allowin), 32'd1, "ex_allowin with stage empty");
                check_fwd(ex_fwd, fwd_exp, 1'b0, "ex_fwd flags with stage empty");
            end else begin
                v   = make_item(pending[0]);
                res = vec[pending[0] * NF + 9];
                fwd_exp.res_from_mem = v.res_from_mem;
                fwd_exp.rf_we        = v.rf_we;
                fwd_exp.rf_waddr     = v.rf_waddr;
                fwd_exp.alu_result   = res;
                check_fwd(ex_fwd, fwd_exp, ex_to_mem_valid, "ex_fwd");
                if (!(v.alu_op inside {DIV, DIVU, MOD, MODU}))
                    check_word(32'(ex_to_mem_valid), 32'd1, "single-cycle op not complete");
                if (ex_to_mem_valid) begin
                    check_word(ex_to_mem.alu_result, res,
                               $sformatf("result of vector %0d", pending[0]));
                    to_mem_exp.pc           = v.pc;
                    to_mem_exp.res_from_mem = v.res_from_mem;
                    to_mem_exp.rf_we        = v.rf_we;
                    to_mem_exp.rf_waddr     = v.rf_waddr;
                    to_mem_exp.alu_result   = res;
                    to_mem_exp.addr_low     = res[1:0];
                    to_mem_exp.size         = v.size;
                    to_mem_exp.ld_unsigned  = v.ld_unsigned;
                    check_to_mem(ex_to_mem, to_mem_exp, "ex_to_mem");
                    check_mem_req(mem_req, expect_req(v, res, later_excep), "mem_req");
                end
            end
            if (hold_prev) begin
                check_word(32'(ex_to_mem_valid), 32'd1, "item lost under back-pressure");
                check_to_mem(ex_to_mem, to_mem_prev, "ex_to_mem moved under back-pressure");
                if (later_excep == lx_prev)
                    check_mem_req(mem_req, req_prev, "mem_req moved under back-pressure");
            end
            hold_prev   = ex_to_mem_valid && !mem_allowin && !flush;
            to_mem_prev = ex_to_mem;
            req_prev    = mem_req;
            lx_prev     = later_excep;
            if (resetn) begin                   // what the coming edge does
                if (flush) begin
                    pending.delete();
                end else begin
                    if (ex_to_mem_valid && mem_allowin) begin
                        void'(pending.pop_front());
                        departed++;
                    end
                    if (id_to_ex_valid && ex_allowin) pending.push_back(cur_vec);
                end
            end
        end
    end

    initial begin
        $readmemh("tb/ex_vectors.txt", vec);
        resetn         <= 1'b0;
        flush          <= 1'b0;
        later_excep    <= 1'b0;
        id_to_ex_valid <= 1'b0;
        id_to_ex       <= '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < FLUSH_IDX; i++) send(i);
        send(FLUSH_IDX);
        @(posedge clk);
        id_to_ex_valid <= 1'b0;
        repeat (6) @(posedge clk);               // divider is mid-run here
        cur_vec = NV - 1;
        flush          <= 1'b1;
        id_to_ex_valid <= 1'b1;                  // dropped along with the flush
        id_to_ex       <= make_item(NV - 1);
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        while (!ex_allowin) @(negedge clk);
        @(posedge clk);
        id_to_ex_valid <= 1'b0;
        do @(posedge clk); while (pending.size() != 0);
        repeat (2) @(posedge clk);
        if (departed != NV - 1)
            $display("vector count mismatch: %0d results left the stage, %0d expected",
                     departed, NV - 1);
        $display("checks %0d, errors %0d, results %0d", checks, errors, departed);
        if (errors == 0 && departed == NV - 1) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb/ex_vectors.txt */
// op src1 src2 rkd_value size mem_we res_from_mem rf_we rf_waddr expected_result
// op 0 add .. b lui, c div, d divu, e mod, f modu; size 0 byte, 1 half, 2 word
0 00000005 00000007 00000000 2 0 0 1 01 0000000c
1 00000003 00000005 00000000 2 0 0 1 02 fffffffe
2 ffffffff 00000001 00000000 2 0 0 1 03 00000001
3 ffffffff 00000001 00000000 2 0 0 1 04 00000000
4 f0f0ff00 0ff00ff0 00000000 2 0 0 1 05 00f00f00
5 12340000 00005678 00000000 2 0 0 1 06 12345678
6 0000ffff 00ff0000 00000000 2 0 0 1 07 ff000000
7 aaaa5555 ffff0000 00000000 2 0 0 1 08 55555555
8 00000001 00000024 00000000 2 0 0 1 09 00000010
9 80000000 0000001f 00000000 2 0 0 1 0a 00000001
a 80000000 00000004 00000000 2 0 0 1 0b f8000000
b 00000000 12345000 00000000 2 0 0 1 0c 12345000
c 00000064 fffffff9 00000000 2 0 0 1 0d fffffff2
e fffffff9 00000002 00000000 2 0 0 1 0e ffffffff
d 00000064 00000007 00000000 2 0 0 1 0f 0000000e
f 00000064 00000007 00000000 2 0 0 1 10 00000002
c 00000007 00000000 00000000 2 0 0 1 11 ffffffff
e fffffff9 00000000 00000000 2 0 0 1 12 fffffff9
0 00001000 00000003 000000a5 0 1 0 0 00 00001003
0 00001000 00000002 0000beef 1 1 0 0 00 00001002
0 00001000 00000008 12345678 2 1 0 0 00 00001008
0 00002000 00000004 00000000 2 0 1 1 13 00002004
c 40000000 00000003 00000000 2 0 0 1 14 15555555
d ffffffff 00000010 00000000 2 0 0 1 15 0fffffff

/* files.f */
src/ex_pkg.sv
src/div_count.sv
src/div_ctrl.sv
src/div_core.sv
src/ex_alu.sv
src/ex_stage.sv
src/ex_top.sv
tb/tb_ex_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 --top-module tb_ex_top -f files.f --Mdir obj_dir -o tb_ex_top \
    && ./obj_dir/tb_ex_top > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
